/* hw/icache_cfg_pkg.sv */
package icache_cfg_pkg;

  // byte address on the fetch side and on the bus
  typedef logic [31:0] addr_t;
  // one instruction, also one bus beat
  typedef logic [31:0] word_t;

  // address split: tag | index | word | byte
  typedef logic [18:0] tag_t;
  typedef logic [6:0]  index_t;
  typedef logic [3:0]  word_sel_t;

  localparam int OFFSET_BITS    = 6;
  localparam int BEATS_PER_LINE = 16;
  // axi len field, beats minus one
  localparam logic [7:0] BURST_LEN = 8'd15;

  // tag store payload
  typedef struct packed {
    tag_t tag;
  } tag_entry_t;

  // data store address, one word per entry
  typedef struct packed {
    index_t    index;
    word_sel_t word;
  } data_addr_t;

  typedef enum logic [2:0] {RESET, IDLE, LOOKUP, REFILL, UNCACHED} ctrl_state_t;

endpackage

/* hw/icache_bus_pkg.sv */
package icache_bus_pkg;

  // fetch request, byte address of the instruction
  typedef struct packed {
    icache_cfg_pkg::addr_t addr;
  } fetch_req_t;

  // fetch response, one aligned word
  typedef struct packed {
    icache_cfg_pkg::word_t data;
  } fetch_rsp_t;

  // axi4 read address channel payload
  typedef struct packed {
    icache_cfg_pkg::addr_t addr;
    // beats minus one
    logic [7:0]            len;
  } mem_ar_t;

  // axi4 read data channel payload
  typedef struct packed {
    icache_cfg_pkg::word_t data;
    logic                  last;
  } mem_r_t;

endpackage

/* hw/icache_sram.sv */
`timescale 1ns/1ps

module icache_sram #(
  parameter int  DEPTH   = 2048,
  parameter type entry_t = icache_cfg_pkg::word_t
) (
  input  logic                     clk,
  input  logic [$clog2(DEPTH)-1:0] addr_i,
  input  logic                     we_i,
  input  entry_t                   wdata_i,
  output entry_t                   rdata_o
);

  // storage array, contents undefined after power up
  entry_t mem_q [DEPTH];

  // write port
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  // registered read, old data on a same-cycle write
  always_ff @(posedge clk) begin
    rdata_o <= mem_q[addr_i];
  end

  // writes stay inside the array
  a_write_in_range: assert property (
    @(posedge clk) we_i |-> (int'(addr_i) < DEPTH)
  );

endmodule

/* hw/icache_ctrl.sv */
`timescale 1ns/1ps

module icache_ctrl #(
  parameter icache_cfg_pkg::addr_t UNCACHED_BASE = 32'h8000_0000
) (
  input  logic                       clk,
  input  logic                       rst,
  // fetch port
  input  logic                       fetch_valid_i,
  output logic                       fetch_ready_o,
  input  icache_bus_pkg::fetch_req_t fetch_req_i,
  output logic                       rsp_valid_o,
  output icache_bus_pkg::fetch_rsp_t rsp_o,
  // axi4 read address channel
  output logic                       ar_valid_o,
  input  logic                       ar_ready_i,
  output icache_bus_pkg::mem_ar_t    ar_o,
  // axi4 read data channel
  input  logic                       r_valid_i,
  output logic                       r_ready_o,
  input  icache_bus_pkg::mem_r_t     r_i,
  // tag store
  output icache_cfg_pkg::index_t     tag_addr_o,
  output logic                       tag_we_o,
  output icache_cfg_pkg::tag_entry_t tag_wdata_o,
  input  icache_cfg_pkg::tag_entry_t tag_rdata_i,
  // data store
  output icache_cfg_pkg::data_addr_t data_addr_o,
  output logic                       data_we_o,
  output icache_cfg_pkg::word_t      data_wdata_o,
  input  icache_cfg_pkg::word_t      data_rdata_i
);

  icache_cfg_pkg::ctrl_state_t state_q;
  icache_cfg_pkg::addr_t       addr_q;
  icache_cfg_pkg::word_sel_t   burst_cnt_q;
  logic [127:0]                valid_q;
  // one cycle after the last beat, stores re-read at the fetch address
  logic                        reread_q;

  // read request register
  logic                    ar_valid_q;
  icache_bus_pkg::mem_ar_t ar_q;

  // fields of the incoming and the latched address
  icache_cfg_pkg::tag_t      tag_q;
  icache_cfg_pkg::index_t    idx_q;
  icache_cfg_pkg::word_sel_t word_q;
  icache_cfg_pkg::index_t    req_idx;
  icache_cfg_pkg::word_sel_t req_word;

  logic accept;
  logic beat;
  logic refill_beat;
  logic uncached;
  logic hit;

  assign tag_q    = addr_q[31:13];
  assign idx_q    = addr_q[12:6];
  assign word_q   = addr_q[5:2];
  assign req_idx  = fetch_req_i.addr[12:6];
  assign req_word = fetch_req_i.addr[5:2];

  // handshakes
  assign fetch_ready_o = (state_q == icache_cfg_pkg::IDLE);
  assign accept        = fetch_valid_i && fetch_ready_o;
  assign r_ready_o     = (state_q == icache_cfg_pkg::REFILL && !reread_q) ||
                         (state_q == icache_cfg_pkg::UNCACHED);
  assign beat          = r_valid_i && r_ready_o;
  assign refill_beat   = beat && (state_q == icache_cfg_pkg::REFILL);

  // lookup decision, only meaningful in LOOKUP
  assign uncached = (addr_q >= UNCACHED_BASE);
  assign hit      = valid_q[idx_q] && (tag_rdata_i.tag == tag_q);

  // store addressing
  // idle reads straight from the request so data is ready in LOOKUP
  always_comb begin
    if (state_q == icache_cfg_pkg::IDLE) begin
      tag_addr_o        = req_idx;
      data_addr_o.index = req_idx;
      data_addr_o.word  = req_word;
    end else begin
      tag_addr_o        = idx_q;
      data_addr_o.index = idx_q;
      // burst counter picks the word while beats arrive
      if (state_q == icache_cfg_pkg::REFILL && !reread_q) begin
        data_addr_o.word = burst_cnt_q;
      end else begin
        data_addr_o.word = word_q;
      end
    end
  end

  // beats go into the line as they come
  assign data_we_o       = refill_beat;
  assign data_wdata_o    = r_i.data;
  // tag written together with the last beat
  assign tag_we_o        = refill_beat && r_i.last;
  assign tag_wdata_o.tag = tag_q;

  assign ar_valid_o = ar_valid_q;
  assign ar_o       = ar_q;

  // control FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= icache_cfg_pkg::RESET;
      valid_q     <= '0;
      burst_cnt_q <= '0;
      reread_q    <= 1'b0;
      ar_valid_q  <= 1'b0;
      rsp_valid_o <= 1'b0;
    end else begin
      // response is a single pulse
      rsp_valid_o <= 1'b0;
      if (ar_valid_q && ar_ready_i) begin
        ar_valid_q <= 1'b0;
      end
      case (state_q)
        icache_cfg_pkg::RESET: begin
          state_q <= icache_cfg_pkg::IDLE;
        end
        icache_cfg_pkg::IDLE: begin
          if (accept) begin
            state_q <= icache_cfg_pkg::LOOKUP;
          end
        end
        icache_cfg_pkg::LOOKUP: begin
          if (uncached) begin
            ar_valid_q <= 1'b1;
            state_q    <= icache_cfg_pkg::UNCACHED;
          end else if (hit) begin
            rsp_valid_o <= 1'b1;
            state_q     <= icache_cfg_pkg::IDLE;
          end else begin
            // miss, refill whole line from word 0
            ar_valid_q  <= 1'b1;
            burst_cnt_q <= '0;
            state_q     <= icache_cfg_pkg::REFILL;
          end
        end
        icache_cfg_pkg::REFILL: begin
          if (reread_q) begin
            reread_q <= 1'b0;
            state_q  <= icache_cfg_pkg::LOOKUP;
          end else if (beat) begin
            burst_cnt_q <= burst_cnt_q + 1'b1;
            if (r_i.last) begin
              valid_q[idx_q] <= 1'b1;
              reread_q       <= 1'b1;
            end
          end
        end
        icache_cfg_pkg::UNCACHED: begin
          if (beat) begin
            rsp_valid_o <= 1'b1;
            state_q     <= icache_cfg_pkg::IDLE;
          end
        end
        default: begin
          state_q <= icache_cfg_pkg::IDLE;
        end
      endcase
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= fetch_req_i.addr;
    end
    // request built in LOOKUP, held until the handshake
    if (state_q == icache_cfg_pkg::LOOKUP) begin
      if (uncached) begin
        // single beat, len 0
        ar_q.addr <= {addr_q[31:2], 2'b00};
        ar_q.len  <= 8'd0;
      end else begin
        ar_q.addr <= {tag_q, idx_q, {icache_cfg_pkg::OFFSET_BITS{1'b0}}};
        ar_q.len  <= icache_cfg_pkg::BURST_LEN;
      end
    end
    if (state_q == icache_cfg_pkg::LOOKUP && hit) begin
      rsp_o.data <= data_rdata_i;
    end else if (state_q == icache_cfg_pkg::UNCACHED && beat) begin
      rsp_o.data <= r_i.data;
    end
  end

  // request held steady while memory stalls it
  a_ar_stable: assert property (
    @(posedge clk) disable iff (rst)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o)
  );

  // no response while a line is still arriving
  a_no_rsp_in_refill: assert property (
    @(posedge clk) disable iff (rst)
    (state_q == icache_cfg_pkg::REFILL) |-> !rsp_valid_o
  );

  // memory burst length agrees with the line size
  a_last_on_final_beat: assert property (
    @(posedge clk) disable iff (rst)
    refill_beat && r_i.last |->
      burst_cnt_q == icache_cfg_pkg::word_sel_t'(icache_cfg_pkg::BEATS_PER_LINE - 1)
  );

endmodule

/* hw/icache_top.sv */
`timescale 1ns/1ps

module icache_top #(
  parameter icache_cfg_pkg::addr_t UNCACHED_BASE = 32'h8000_0000
) (
  input  logic                       clk,
  input  logic                       rst,
  // fetch port
  input  logic                       fetch_valid_i,
  output logic                       fetch_ready_o,
  input  icache_bus_pkg::fetch_req_t fetch_req_i,
  output logic                       rsp_valid_o,
  output icache_bus_pkg::fetch_rsp_t rsp_o,
  // axi4 read channels
  output logic                       ar_valid_o,
  input  logic                       ar_ready_i,
  output icache_bus_pkg::mem_ar_t    ar_o,
  input  logic                       r_valid_i,
  output logic                       r_ready_o,
  input  icache_bus_pkg::mem_r_t     r_i
);

  // tag store port
  icache_cfg_pkg::index_t     tag_addr;
  logic                       tag_we;
  icache_cfg_pkg::tag_entry_t tag_wdata;
  icache_cfg_pkg::tag_entry_t tag_rdata;
  // data store port
  icache_cfg_pkg::data_addr_t data_addr;
  logic                       data_we;
  icache_cfg_pkg::word_t      data_wdata;
  icache_cfg_pkg::word_t      data_rdata;

  icache_ctrl #(
    .UNCACHED_BASE(UNCACHED_BASE)
  ) u_icache_ctrl (
    .clk          (clk),
    .rst          (rst),
    .fetch_valid_i(fetch_valid_i),
    .fetch_ready_o(fetch_ready_o),
    .fetch_req_i  (fetch_req_i),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_o        (rsp_o),
    .ar_valid_o   (ar_valid_o),
    .ar_ready_i   (ar_ready_i),
    .ar_o         (ar_o),
    .r_valid_i    (r_valid_i),
    .r_ready_o    (r_ready_o),
    .r_i          (r_i),
    .tag_addr_o   (tag_addr),
    .tag_we_o     (tag_we),
    .tag_wdata_o  (tag_wdata),
    .tag_rdata_i  (tag_rdata),
    .data_addr_o  (data_addr),
    .data_we_o    (data_we),
    .data_wdata_o (data_wdata),
    .data_rdata_i (data_rdata)
  );

  // one tag per line
  icache_sram #(
    .DEPTH  (128),
    .entry_t(icache_cfg_pkg::tag_entry_t)
  ) u_tag_store (
    .clk    (clk),
    .addr_i (tag_addr),
    .we_i   (tag_we),
    .wdata_i(tag_wdata),
    .rdata_o(tag_rdata)
  );

  // 128 lines of 16 words
  icache_sram #(
    .DEPTH  (2048),
    .entry_t(icache_cfg_pkg::word_t)
  ) u_data_store (
    .clk    (clk),
    .addr_i (data_addr),
    .we_i   (data_we),
    .wdata_i(data_wdata),
    .rdata_o(data_rdata)
  );

endmodule

/* tests/icache_mem_model.sv */
`timescale 1ns/1ps

module icache_mem_model (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    ar_valid_i,
  output logic                    ar_ready_o,
  input  icache_bus_pkg::mem_ar_t ar_i,
  output logic                    r_valid_o,
  input  logic                    r_ready_i,
  output icache_bus_pkg::mem_r_t  r_o,
  output int unsigned             ar_count_o,
  output logic [7:0]              last_len_o,
  output icache_cfg_pkg::addr_t   last_addr_o
);

  logic                  busy;
  logic                  ar_hs;
  logic                  r_hs;
  icache_cfg_pkg::addr_t beat_addr;
  logic [7:0]            beats_left;

  initial begin
    ar_ready_o  = 1'b0;
    r_valid_o   = 1'b0;
    r_o         = '0;
    ar_count_o  = 0;
    last_len_o  = '0;
    last_addr_o = '0;
    busy        = 1'b0;
    beat_addr   = '0;
    beats_left  = '0;
    forever begin
      // handshakes as the coming rising edge sees them
      @(negedge clk);
      ar_hs = ar_valid_i && ar_ready_o && !rst;
      r_hs  = r_valid_o && r_ready_i && !rst;
      if (ar_hs) begin
        ar_count_o  = ar_count_o + 1;
        last_len_o  = ar_i.len;
        last_addr_o = ar_i.addr;
      end
      @(posedge clk);
      #1;
      if (rst) begin
        busy      = 1'b0;
        r_valid_o = 1'b0;
      end else if (ar_hs) begin
        busy       = 1'b1;
        beat_addr  = last_addr_o;
        beats_left = last_len_o;
      end else if (r_hs) begin
        if (beats_left == 8'd0) begin
          busy = 1'b0;
        end else begin
          beats_left = beats_left - 8'd1;
          // consecutive words through the burst
          beat_addr  = beat_addr + 32'd4;
        end
      end
      // one burst at a time, random gaps on both channels
      ar_ready_o = !rst && !busy && (($urandom % 4) != 0);
      if (!busy) begin
        r_valid_o = 1'b0;
      end else if (!r_valid_o || r_hs) begin
        // a raised valid waits for its handshake
        r_valid_o = ($urandom % 4) != 0;
      end
      // memory word at byte address A holds ~A
      r_o.data = ~beat_addr;
      r_o.last = (beats_left == 8'd0);
    end
  end

endmodule

/* tests/icache_tb.sv */
`timescale 1ns/1ps

module icache_tb;

  localparam icache_cfg_pkg::addr_t UNCACHED_BASE  = 32'h8000_0000;
  localparam int unsigned           TIMEOUT_CYCLES = 40000;
  localparam int unsigned           SEED           = 32'hb162_4adc;

  logic                       clk;
  logic                       rst;
  logic                       fetch_valid;
  logic                       fetch_ready;
  icache_bus_pkg::fetch_req_t fetch_req;
  logic                       rsp_valid;
  icache_bus_pkg::fetch_rsp_t rsp;
  logic                       ar_valid;
  logic                       ar_ready;
  icache_bus_pkg::mem_ar_t    ar;
  logic                       r_valid;
  logic                       r_ready;
  icache_bus_pkg::mem_r_t     r;
  int unsigned                ar_count;
  logic [7:0]                 last_len;
  icache_cfg_pkg::addr_t      last_addr;

  int unsigned           cycle = 0;
  int unsigned           accepted = 0;
  int unsigned           responses = 0;
  int unsigned           accept_cycle = 0;
  int unsigned           rsp_cycle = 0;
  icache_cfg_pkg::addr_t fetch_addr = '0;
  // expected cache contents, tracked from the address split alone
  logic [127:0]          line_valid = '0;
  logic [18:0]           line_tag [128];

  icache_top #(
    .UNCACHED_BASE(UNCACHED_BASE)
  ) i_icache_top (
    .clk          (clk),
    .rst          (rst),
    .fetch_valid_i(fetch_valid),
    .fetch_ready_o(fetch_ready),
    .fetch_req_i  (fetch_req),
    .rsp_valid_o  (rsp_valid),
    .rsp_o        (rsp),
    .ar_valid_o   (ar_valid),
    .ar_ready_i   (ar_ready),
    .ar_o         (ar),
    .r_valid_i    (r_valid),
    .r_ready_o    (r_ready),
    .r_i          (r)
  );

  icache_mem_model u_mem_model (
    .clk        (clk),
    .rst        (rst),
    .ar_valid_i (ar_valid),
    .ar_ready_o (ar_ready),
    .ar_i       (ar),
    .r_valid_o  (r_valid),
    .r_ready_i  (r_ready),
    .r_o        (r),
    .ar_count_o (ar_count),
    .last_len_o (last_len),
    .last_addr_o(last_addr)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // memory content rule, inverse of the byte address
  function automatic icache_cfg_pkg::word_t mem_word(input icache_cfg_pkg::addr_t addr);
    return ~addr;
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      fail_run($sformatf("ERROR: %s = 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else fail_run(what);
  endtask

  // run limit
  always @(posedge clk) begin
    cycle <= cycle + 1;
    check_true(cycle < TIMEOUT_CYCLES, "timeout, fetches did not finish within the cycle limit");
  end

  // every response against the reference
  always @(negedge clk) begin
    if (!rst && rsp_valid) begin
      check_true(responses < accepted, "rsp_valid_o pulsed with no fetch outstanding");
      check_hex("rsp_o.data", rsp.data, mem_word({fetch_addr[31:2], 2'b00}));
      rsp_cycle = cycle;
      responses = responses + 1;
    end
  end

  // one fetch, from request to response
  task automatic run_fetch(input icache_cfg_pkg::addr_t addr, output int unsigned latency,
                           output int unsigned new_ar);
    int unsigned ar_before;
    int unsigned rsp_before;
    ar_before      = ar_count;
    rsp_before     = responses;
    fetch_addr     = addr;
    fetch_valid    = 1'b1;
    fetch_req.addr = addr;
    // taken at the first edge that sees ready
    do begin
      @(negedge clk);
    end while (!fetch_ready);
    accept_cycle = cycle;
    @(posedge clk);
    #1;
    accepted    = accepted + 1;
    fetch_valid = 1'b0;
    while (responses == rsp_before) begin
      @(posedge clk);
    end
    #1;
    latency = rsp_cycle - accept_cycle;
    new_ar  = ar_count - ar_before;
  endtask

  task automatic fetch_and_check(input icache_cfg_pkg::addr_t addr);
    int unsigned lat;
    int unsigned new_ar;
    logic [6:0]  idx;
    logic [18:0] tag;
    logic        resident;
    idx      = addr[12:6];
    tag      = addr[31:13];
    resident = line_valid[idx] && (line_tag[idx] == tag);
    run_fetch(addr, lat, new_ar);
    if (addr >= UNCACHED_BASE) begin
      // single beat at the word address, lines left alone
      check_hex("uncached ar handshakes", new_ar, 32'd1);
      check_hex("ar_o.len", 32'(last_len), 32'd0);
      check_hex("ar_o.addr", last_addr, {addr[31:2], 2'b00});
    end else if (resident) begin
      check_hex("hit ar handshakes", new_ar, 32'd0);
      check_hex("rsp_valid_o latency", lat, 32'd2);
    end else begin
      check_hex("refill ar handshakes", new_ar, 32'd1);
      check_hex("ar_o.len", 32'(last_len), 32'd15);
      check_hex("ar_o.addr", last_addr, {addr[31:6], 6'b0});
      line_valid[idx] = 1'b1;
      line_tag[idx]   = tag;
    end
  endtask

  initial begin
    icache_cfg_pkg::addr_t a;
    void'($urandom(SEED));
    rst         = 1'b1;
    fetch_valid = 1'b0;
    fetch_req   = '0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    // one cycle in RESET before the port opens
    @(negedge clk);
    check_hex("fetch_ready_o", 32'(fetch_ready), 32'd0);
    // bus and response quiet out of reset
    repeat (4) begin
      @(negedge clk);
      check_hex("fetch_ready_o", 32'(fetch_ready), 32'd1);
      check_hex("ar_valid_o", 32'(ar_valid), 32'd0);
      check_hex("r_ready_o", 32'(r_ready), 32'd0);
      check_hex("rsp_valid_o", 32'(rsp_valid), 32'd0);
    end
    @(posedge clk);
    #1;
    // first fetch is a refill
    fetch_and_check(32'h0000_1234);
    // random fetches over eight lines
    repeat (64) begin
      fetch_and_check(32'h0001_0000 + ($urandom % 8) * 64 + ($urandom % 64));
    end
    // whole line again, all hits
    fetch_and_check(32'h0001_0000);
    for (int w = 0; w < 16; w++) begin
      fetch_and_check(32'h0001_0000 + 32'(w) * 4);
    end
    // same index, two tags
    a = 32'h0000_4a48;
    repeat (6) begin
      fetch_and_check(a);
      fetch_and_check(a + 32'h2000);
    end
    // uncached region, a handshake every time
    repeat (4) begin
      fetch_and_check(32'h8000_0106);
    end
    fetch_and_check(UNCACHED_BASE);
    fetch_and_check(32'hffff_fffe);
    // mixed traffic under random stalls
    repeat (200) begin
      if (($urandom % 8) == 0) begin
        fetch_and_check(UNCACHED_BASE + ($urandom % 256));
      end else begin
        fetch_and_check(($urandom % 2) * 32'h2000 + ($urandom % 8) * 64 + ($urandom % 64));
      end
    end
    // room for a stray pulse to show
    repeat (4) @(negedge clk);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* tb.f */
hw/icache_cfg_pkg.sv
hw/icache_bus_pkg.sv
hw/icache_sram.sv
hw/icache_ctrl.sv
hw/icache_top.sv
tests/icache_mem_model.sv
tests/icache_tb.sv

/* Makefile */
TOOL      = verilator
FLAGS     = --binary --assert --timing
TOP       = icache_tb
FILELIST  = tb.f
BUILD_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# exit status of the simulation is the result
run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
